// ==== Bender.yml ====
package:
  name: coeff_token

sources:
  - files:
      - verilog/cavlcPkg.sv
      - verilog/laneIf.sv
      - verilog/coeffTokenVlc3.sv
      - verilog/coeffTokenLane.sv
      - verilog/blockDispatcher.sv
      - verilog/bitPacker.sv
      - verilog/coeffTokenTop.sv
  - target: test
    files:
      - verif/coeffTokenChecker.sv
      - verif/coeffTokenTb.sv

// ==== all.f ====
verilog/cavlcPkg.sv
verilog/laneIf.sv
verilog/coeffTokenVlc3.sv
verilog/coeffTokenLane.sv
verilog/blockDispatcher.sv
verilog/bitPacker.sv
verilog/coeffTokenTop.sv
verif/coeffTokenChecker.sv
verif/coeffTokenTb.sv

// ==== verif/coeffTokenChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenChecker (
        input logic clk,
        input logic rstN,
        input logic rowValid,
        input logic flush,
        input logic wordValid,
        input logic lowNcValid,
        input cavlcPkg::blkIdx_t lowNcIdx
);
        int failCount = 0;

        assert property (@(posedge clk) disable iff (!rstN) rowValid |=> !rowValid)
                else begin
                        $error("rowValid strobes closer than two cycles");
                        failCount++;
                end

        assert property (@(posedge clk) disable iff (!rstN) !(flush && rowValid))
                else begin
                        $error("flush together with rowValid");
                        failCount++;
                end

        // no output strobe may leave the design while it is held in reset.
        assert property (@(posedge clk) !rstN |-> !wordValid && !lowNcValid)
                else begin
                        $error("output strobe during reset");
                        failCount++;
                end

        // a strobe that reads an unwritten queue slot shows an undefined index.
        assert property (@(posedge clk) disable iff (!rstN) lowNcValid |-> !$isunknown(lowNcIdx))
                else begin
                        $error("lowNcIdx undefined while lowNcValid was high");
                        failCount++;
                end

endmodule

bind coeffTokenTop coeffTokenChecker uChecker (.*);

`default_nettype wire

// ==== verif/coeffTokenTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenTb;
        import cavlcPkg::*;

        localparam int TIMEOUT_CYCLES = 200;

        logic clk;
        logic rstN;
        logic rowValid;
        logic firstRow;
        coeffCnt_t totalCoeff [NUM_LANES];
        trailOnes_t trailOnes [NUM_LANES];
        logic flush;
        logic wordValid;
        word_t word;
        logic lowNcValid;
        blkIdx_t lowNcIdx;
        nc_t lowNcVal;

        bit expBits [$];                        // model bit stream with the oldest bit first.
        word_t expWords [$];
        logic [6:0] expLow [$];                 // {index, nC} of skipped blocks.
        word_t gotWords [$];
        logic [6:0] gotLow [$];
        int prevCnt [NUM_LANES];
        bit haveTop;

        coeffTokenTop i_dut (
                .clk(clk), .rstN(rstN), .rowValid(rowValid), .firstRow(firstRow),
                .totalCoeff0(totalCoeff[0]), .totalCoeff1(totalCoeff[1]),
                .totalCoeff2(totalCoeff[2]), .totalCoeff3(totalCoeff[3]),
                .trailOnes0(trailOnes[0]), .trailOnes1(trailOnes[1]),
                .trailOnes2(trailOnes[2]), .trailOnes3(trailOnes[3]),
                .flush(flush), .wordValid(wordValid), .word(word),
                .lowNcValid(lowNcValid), .lowNcIdx(lowNcIdx), .lowNcVal(lowNcVal)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #4 clk = ~clk;
                end
        end

        task automatic abort(input string why);
                $display("%s", why);
                $display("*** TEST FAILED ***");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic checkValue(input string name, input logic [31:0] got,
                        input logic [31:0] exp);
                if (got !== exp) begin
                        abort($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
                end
        endtask

        // outputs only move after the rising edge, so the falling edge sees them settled.
        always @(negedge clk) begin
                if (rstN && wordValid) begin
                        gotWords.push_back(word);
                end
                if (rstN && lowNcValid) begin
                        gotLow.push_back({lowNcIdx, lowNcVal});
                end
                if (i_dut.uChecker.failCount != 0) begin
                        abort("an assertion in coeffTokenChecker failed");
                end
        end

        function automatic int refNc(input bit aAvail, input int a, input bit bAvail, input int b);
                if (aAvail && bAvail) begin
                        return (a + b + 1) >> 1;
                end else if (aAvail) begin
                        return a;
                end else if (bAvail) begin
                        return b;
                end
                return 0;
        endfunction

        // table codes for 4 <= nC < 8 keyed by trailing ones * 100 + total.
        task automatic refCode(input int ones, input int total, output int code, output int len);
                int entry;
                case (ones * 100 + total)
                        0: entry = (4 << 16) | 'b1111;
                        101: entry = (4 << 16) | 'b1110;
                        202: entry = (4 << 16) | 'b1101;
                        303: entry = (4 << 16) | 'b1100;
                        1: entry = (6 << 16) | 'b001111;
                        16: entry = (10 << 16) | 'b0000000001;
                        316: entry = (10 << 16) | 'b0000000010;
                        default: abort($sformatf("no reference code for ones %0d total %0d",
                                ones, total));
                endcase
                code = entry & 'hffff;
                len = entry >> 16;
        endtask

        task automatic packFullWords();
                word_t w;
                while (expBits.size() >= 32) begin
                        for (int i = 0; i < 32; i++) begin
                                w = {w[30:0], expBits.pop_front()};
                        end
                        expWords.push_back(w);
                end
        endtask

        task automatic modelRow(input int cnt [NUM_LANES], input int ones [NUM_LANES],
                        input bit first);
                int nc;
                int left;
                int code;
                int len;
                for (int b = 0; b < NUM_LANES; b++) begin
                        left = (b > 0) ? cnt[b > 0 ? b - 1 : 0] : 0;
                        nc = refNc(b > 0, left, haveTop && !first, prevCnt[b]);
                        if (nc < 4) begin
                                expLow.push_back({2'(b), 5'(nc)});
                                continue;
                        end
                        if (nc >= 8) begin
                                len = 6;
                                code = (cnt[b] == 0) ? 'b000011 : (((cnt[b] - 1) << 2) | ones[b]);
                        end else begin
                                refCode(ones[b], cnt[b], code, len);
                        end
                        for (int i = len - 1; i >= 0; i--) begin
                                expBits.push_back(code[i]);
                        end
                        packFullWords();
                end
                prevCnt = cnt;
                haveTop = 1'b1;
        endtask

        task automatic sendRow(input int cnt [NUM_LANES], input int ones [NUM_LANES],
                        input bit first);
                modelRow(cnt, ones, first);
                @(negedge clk);
                rowValid = 1'b1;
                firstRow = first;
                for (int b = 0; b < NUM_LANES; b++) begin
                        totalCoeff[b] = cnt[b];
                        trailOnes[b] = ones[b];
                end
                @(negedge clk);
                rowValid = 1'b0;                // leaves a gap of one cycle.
        endtask

        task automatic sendFlush();
                if (expBits.size() > 0) begin
                        while (expBits.size() < 32) begin
                                expBits.push_back(1'b0);
                        end
                        packFullWords();
                end
                @(negedge clk);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
        endtask

        task automatic waitOutputs(input string what);
                int cycles;
                cycles = 0;
                while (gotWords.size() < expWords.size() || gotLow.size() < expLow.size()) begin
                        if (cycles == TIMEOUT_CYCLES) begin
                                abort($sformatf("timed out waiting for the outputs of %s", what));
                        end
                        @(negedge clk);
                        cycles++;
                end
        endtask

        task automatic compareOutputs();
                logic [6:0] got;
                logic [6:0] exp;
                while (expWords.size() > 0) begin
                        checkValue("word", gotWords.pop_front(), expWords.pop_front());
                end
                while (expLow.size() > 0) begin
                        got = gotLow.pop_front();
                        exp = expLow.pop_front();
                        checkValue("lowNcIdx", got[6:5], exp[6:5]);
                        checkValue("lowNcVal", got[4:0], exp[4:0]);
                end
        endtask

        task automatic fixedLengthTest();
                sendRow('{16, 12, 9, 8}, '{3, 2, 1, 0}, 1'b1);
                sendFlush();
                waitOutputs("fixed-length test");
                compareOutputs();
        endtask

        task automatic midRangeTest();
                sendRow('{16, 16, 16, 16}, '{0, 1, 2, 3}, 1'b1);
                sendRow('{4, 8, 9, 10}, '{0, 1, 2, 3}, 1'b0);
                sendRow('{1, 2, 3, 16}, '{0, 2, 3, 3}, 1'b0);   // nC comes out as 4, 5, 6, 7.
                sendFlush();
                waitOutputs("mid-range test");
                compareOutputs();
        endtask

        // a flush here must give no word, or the next test sees one too many.
        task automatic lowContextTest();
                sendRow('{0, 0, 0, 0}, '{0, 0, 0, 0}, 1'b1);
                sendRow('{0, 0, 0, 0}, '{0, 0, 0, 0}, 1'b0);
                sendFlush();
                waitOutputs("low-context test");
                compareOutputs();
        endtask

        task automatic averagingTest();
                sendRow('{16, 13, 13, 16}, '{0, 0, 0, 0}, 1'b1);
                // block 1 sits at nC 7 and block 2 reaches 8 only by rounding an odd sum.
                sendRow('{1, 2, 10, 0}, '{1, 2, 2, 0}, 1'b0);
                sendFlush();
                waitOutputs("averaging test");
                compareOutputs();
        endtask

        task automatic flushTest();
                int padBits;
                word_t mask;
                sendRow('{16, 16, 16, 16}, '{0, 1, 2, 3}, 1'b1);
                padBits = 32 - expBits.size();
                mask = (word_t'(1) << padBits) - 1;
                sendFlush();
                waitOutputs("flush test");
                checkValue("padding of flushed word", gotWords[$] & mask, '0);
                compareOutputs();
        endtask

        task automatic streamingTest();
                int cnt [NUM_LANES];
                int ones [NUM_LANES];
                for (int r = 0; r < 20; r++) begin
                        for (int b = 0; b < NUM_LANES; b++) begin
                                cnt[b] = 8 + $urandom_range(8);
                                ones[b] = $urandom_range(3);
                        end
                        sendRow(cnt, ones, r == 0);
                end
                sendFlush();
                waitOutputs("streaming test");
                compareOutputs();
        endtask

        initial begin
                void'($urandom(32'h3f1b_e18c));
                rstN = 1'b0;
                rowValid = 1'b0;
                firstRow = 1'b0;
                flush = 1'b0;
                totalCoeff = '{default: '0};
                trailOnes = '{default: '0};
                prevCnt = '{default: 0};
                haveTop = 1'b0;
                repeat (8) @(negedge clk);
                rstN = 1'b1;
                fixedLengthTest();
                midRangeTest();
                lowContextTest();
                averagingTest();
                flushTest();
                streamingTest();
                repeat (8) @(negedge clk);      // room for any stray strobe to show up.
                checkValue("words left over", gotWords.size(), 0);
                checkValue("lowNc strobes left over", gotLow.size(), 0);
                if (i_dut.uChecker.failCount == 0) begin
                        $display("*** TEST PASSED ***");
                        $finish;
                end else begin
                        abort("an assertion in coeffTokenChecker failed");
                end
        end

endmodule

`default_nettype wire

// ==== verilog/bitPacker.sv ====
`timescale 1ns/100ps
`default_nettype none

module bitPacker (
        input logic clk,
        input logic rstN,
        input logic flush,
        laneIf.pack lanes [cavlcPkg::NUM_LANES],
        output logic wordValid,
        output cavlcPkg::word_t word,
        output logic lowNcValid,
        output cavlcPkg::blkIdx_t lowNcIdx,
        output cavlcPkg::nc_t lowNcVal
);
        import cavlcPkg::*;

        logic [BUF_W-1:0] bitBuf;               // right-aligned, the oldest bits on top of fill.
        logic [BUF_W-1:0] appendBuf;
        logic [FILL_W-1:0] fill;
        logic [FILL_W-1:0] addLen;
        logic flushPend;
        logic doPad;
        logic [NUM_LANES-1:0] resValid;
        logic [NUM_LANES-1:0] resSkip;
        code_t resCode [NUM_LANES];
        codeLen_t resLen [NUM_LANES];
        nc_t resNc [NUM_LANES];
        logic [LOWQ_AW:0] wrPtr;
        logic [LOWQ_AW:0] rdPtr;
        logic [LOWQ_AW:0] wrNext;
        logic [LOWQ_AW-1:0] pushSlot [NUM_LANES];
        logic [$bits(blkIdx_t)+$bits(nc_t)-1:0] lowQ [2**LOWQ_AW];

        for (genvar g = 0; g < NUM_LANES; g++) begin : gRes
                assign resValid[g] = lanes[g].resValid;
                assign resSkip[g] = lanes[g].resSkip;
                assign resCode[g] = lanes[g].code;
                assign resLen[g] = lanes[g].codeLen;
                assign resNc[g] = lanes[g].nc;
        end

        // block 0 goes in first, so it ends up on the high side.
        always_comb begin
                appendBuf = bitBuf;
                addLen = '0;
                for (int i = 0; i < NUM_LANES; i++) begin
                        if (resValid[i] && !resSkip[i]) begin
                                appendBuf = (appendBuf << resLen[i]) | BUF_W'(resCode[i]);
                                addLen = addLen + FILL_W'(resLen[i]);
                        end
                end
        end

        assign wordValid = fill >= FILL_W'(WORD_W);
        assign word = word_t'(bitBuf >> (fill - FILL_W'(WORD_W)));

        // pad only once every full word is out and no row is arriving.
        assign doPad = flushPend && !wordValid && (resValid == '0);

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        fill <= '0;
                        flushPend <= 1'b0;
                end else if (doPad) begin
                        fill <= (fill == '0) ? '0 : FILL_W'(WORD_W);
                        flushPend <= 1'b0;
                end else begin
                        fill <= fill - (wordValid ? FILL_W'(WORD_W) : '0) + addLen;
                        if (flush) begin
                                flushPend <= 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (doPad) begin
                        bitBuf <= bitBuf << (FILL_W'(WORD_W) - fill);     // zeros fill the low end.
                end else begin
                        bitBuf <= appendBuf;
                end
        end

        // skipped blocks queue up in block order, one strobe per cycle.
        always_comb begin
                wrNext = wrPtr;
                for (int i = 0; i < NUM_LANES; i++) begin
                        pushSlot[i] = wrNext[LOWQ_AW-1:0];
                        if (resValid[i] && resSkip[i]) begin
                                wrNext = wrNext + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                        if (resValid[i] && resSkip[i]) begin
                                lowQ[pushSlot[i]] <= {blkIdx_t'(i), resNc[i]};
                        end
                end
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                end else begin
                        wrPtr <= wrNext;
                        if (lowNcValid) begin
                                rdPtr <= rdPtr + 1'b1;
                        end
                end
        end

        assign lowNcValid = wrPtr != rdPtr;
        assign {lowNcIdx, lowNcVal} = lowQ[rdPtr[LOWQ_AW-1:0]];

endmodule

`default_nettype wire

// ==== verilog/blockDispatcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module blockDispatcher (
        input logic clk,
        input logic rstN,
        input logic rowValid,
        input logic firstRow,
        input cavlcPkg::coeffCnt_t totalCoeff [cavlcPkg::NUM_LANES],
        input cavlcPkg::trailOnes_t trailOnes [cavlcPkg::NUM_LANES],
        laneIf.dispatch lanes [cavlcPkg::NUM_LANES]
);
        import cavlcPkg::*;

        logic jobValid;
        logic topAvail;                         // a previous row has been seen.
        logic useTop;
        coeffCnt_t topCnt [NUM_LANES];

        // nC from the left (a) and top (b) neighbour counts.
        function automatic nc_t ncOf(input logic aAvail, input coeffCnt_t a,
                        input logic bAvail, input coeffCnt_t b);
                logic [5:0] sum;
                sum = a + b + 6'd1;
                if (aAvail && bAvail) begin
                        return sum[5:1];        // rounded mean.
                end else if (aAvail) begin
                        return a;
                end else if (bAvail) begin
                        return b;
                end
                return '0;
        endfunction

        assign useTop = topAvail && !firstRow;

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        jobValid <= 1'b0;
                        topAvail <= 1'b0;
                end else begin
                        jobValid <= rowValid;
                        if (rowValid) begin
                                topAvail <= 1'b1;
                        end
                end
        end

        // this row becomes the top neighbour row of the next one.
        always_ff @(posedge clk) begin
                if (rowValid) begin
                        topCnt <= totalCoeff;
                end
        end

        for (genvar g = 0; g < NUM_LANES; g++) begin : gJob
                coeffCnt_t leftCnt;
                coeffCnt_t jobCoeff;
                trailOnes_t jobOnes;
                nc_t jobNc;

                if (g == 0) begin : gNoLeft
                        assign leftCnt = '0;
                end else begin : gLeft
                        assign leftCnt = totalCoeff[g-1];
                end

                always_ff @(posedge clk) begin
                        if (rowValid) begin
                                jobCoeff <= totalCoeff[g];
                                jobOnes <= trailOnes[g];
                                jobNc <= ncOf(g != 0, leftCnt, useTop, topCnt[g]);
                        end
                end

                assign lanes[g].jobValid = jobValid;
                assign lanes[g].totalCoeff = jobCoeff;
                assign lanes[g].trailOnes = jobOnes;
                assign lanes[g].nc = jobNc;
        end

endmodule

`default_nettype wire

// ==== verilog/cavlcPkg.sv ====
`default_nettype none

package cavlcPkg;

        localparam int NUM_LANES = 4;           // blocks per row.
        localparam int BUF_W = 96;              // packer bit buffer width.
        localparam int WORD_W = 32;
        localparam int FILL_W = $clog2(BUF_W + 1);
        localparam int LOWQ_AW = 4;             // address width of the low nC queue.

        typedef logic [4:0] coeffCnt_t;         // total coefficients, 0 to 16.
        typedef logic [1:0] trailOnes_t;
        typedef logic [4:0] nc_t;
        typedef logic [15:0] code_t;            // right-aligned code bits.
        typedef logic [4:0] codeLen_t;
        typedef logic [WORD_W-1:0] word_t;
        typedef logic [1:0] blkIdx_t;

endpackage

`default_nettype wire

// ==== verilog/coeffTokenLane.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenLane (
        input logic clk,
        input logic rstN,
        laneIf.lane job
);
        import cavlcPkg::*;

        code_t tabCode;
        codeLen_t tabLen;
        code_t nextCode;
        codeLen_t nextLen;
        coeffCnt_t totalM1;

        coeffTokenVlc3 uVlc3 (
                .totalCoeff(job.totalCoeff),
                .trailOnes(job.trailOnes),
                .code(tabCode),
                .codeLen(tabLen)
        );

        assign totalM1 = job.totalCoeff - 5'd1;

        always_comb begin
                if (job.nc >= 5'd8) begin
                        nextLen = 5'd6;
                        if (job.totalCoeff == '0) begin
                                nextCode = 16'b000011;
                        end else begin
                                nextCode = {10'b0, totalM1[3:0], job.trailOnes};
                        end
                end else begin
                        nextCode = tabCode;     // low nC gets skipped, the value is unused.
                        nextLen = tabLen;
                end
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        job.resValid <= 1'b0;
                end else begin
                        job.resValid <= job.jobValid;
                end
        end

        always_ff @(posedge clk) begin
                if (job.jobValid) begin
                        job.code <= nextCode;
                        job.codeLen <= nextLen;
                        job.resSkip <= job.nc < 5'd4;
                end
        end

endmodule

`default_nettype wire

// ==== verilog/coeffTokenTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenTop (
        input logic clk,
        input logic rstN,
        input logic rowValid,
        input logic firstRow,
        input cavlcPkg::coeffCnt_t totalCoeff0,
        input cavlcPkg::coeffCnt_t totalCoeff1,
        input cavlcPkg::coeffCnt_t totalCoeff2,
        input cavlcPkg::coeffCnt_t totalCoeff3,
        input cavlcPkg::trailOnes_t trailOnes0,
        input cavlcPkg::trailOnes_t trailOnes1,
        input cavlcPkg::trailOnes_t trailOnes2,
        input cavlcPkg::trailOnes_t trailOnes3,
        input logic flush,
        output logic wordValid,
        output cavlcPkg::word_t word,
        output logic lowNcValid,
        output cavlcPkg::blkIdx_t lowNcIdx,
        output cavlcPkg::nc_t lowNcVal
);
        import cavlcPkg::*;

        coeffCnt_t totalCoeff [NUM_LANES];
        trailOnes_t trailOnes [NUM_LANES];

        laneIf lanes [NUM_LANES] ();

        assign totalCoeff = '{totalCoeff0, totalCoeff1, totalCoeff2, totalCoeff3};
        assign trailOnes = '{trailOnes0, trailOnes1, trailOnes2, trailOnes3};

        blockDispatcher uDispatch (
                .clk(clk),
                .rstN(rstN),
                .rowValid(rowValid),
                .firstRow(firstRow),
                .totalCoeff(totalCoeff),
                .trailOnes(trailOnes),
                .lanes(lanes)
        );

        for (genvar g = 0; g < NUM_LANES; g++) begin : gLane
                coeffTokenLane uLane (
                        .clk(clk),
                        .rstN(rstN),
                        .job(lanes[g])
                );
        end

        bitPacker uPack (
                .clk(clk),
                .rstN(rstN),
                .flush(flush),
                .lanes(lanes),
                .wordValid(wordValid),
                .word(word),
                .lowNcValid(lowNcValid),
                .lowNcIdx(lowNcIdx),
                .lowNcVal(lowNcVal)
        );

endmodule

`default_nettype wire

// ==== verilog/coeffTokenVlc3.sv ====
`timescale 1ns/100ps
`default_nettype none

module coeffTokenVlc3 (
        input cavlcPkg::coeffCnt_t totalCoeff,
        input cavlcPkg::trailOnes_t trailOnes,
        output cavlcPkg::code_t code,
        output cavlcPkg::codeLen_t codeLen
);
        import cavlcPkg::*;

        logic [$bits(codeLen_t)+$bits(code_t)-1:0] entry;    // {length, code}.

        always_comb begin
                case ({trailOnes, totalCoeff})
                        {2'd0, 5'd0}: entry = {5'd4, 16'b1111};
                        {2'd0, 5'd1}: entry = {5'd6, 16'b001111};
                        {2'd1, 5'd1}: entry = {5'd4, 16'b1110};
                        {2'd0, 5'd2}: entry = {5'd6, 16'b001011};
                        {2'd1, 5'd2}: entry = {5'd5, 16'b01111};
                        {2'd2, 5'd2}: entry = {5'd4, 16'b1101};
                        {2'd0, 5'd3}: entry = {5'd6, 16'b001000};
                        {2'd1, 5'd3}: entry = {5'd5, 16'b01100};
                        {2'd2, 5'd3}: entry = {5'd5, 16'b01110};
                        {2'd3, 5'd3}: entry = {5'd4, 16'b1100};
                        {2'd0, 5'd4}: entry = {5'd7, 16'b0001111};
                        {2'd1, 5'd4}: entry = {5'd5, 16'b01010};
                        {2'd2, 5'd4}: entry = {5'd5, 16'b01011};
                        {2'd3, 5'd4}: entry = {5'd4, 16'b1011};
                        {2'd0, 5'd5}: entry = {5'd7, 16'b0001011};
                        {2'd1, 5'd5}: entry = {5'd5, 16'b01000};
                        {2'd2, 5'd5}: entry = {5'd5, 16'b01001};
                        {2'd3, 5'd5}: entry = {5'd4, 16'b1010};
                        {2'd0, 5'd6}: entry = {5'd7, 16'b0001001};
                        {2'd1, 5'd6}: entry = {5'd6, 16'b001110};
                        {2'd2, 5'd6}: entry = {5'd6, 16'b001101};
                        {2'd3, 5'd6}: entry = {5'd4, 16'b1001};
                        {2'd0, 5'd7}: entry = {5'd7, 16'b0001000};
                        {2'd1, 5'd7}: entry = {5'd6, 16'b001010};
                        {2'd2, 5'd7}: entry = {5'd6, 16'b001001};
                        {2'd3, 5'd7}: entry = {5'd4, 16'b1000};
                        {2'd0, 5'd8}: entry = {5'd8, 16'b00001111};
                        {2'd1, 5'd8}: entry = {5'd7, 16'b0001110};
                        {2'd2, 5'd8}: entry = {5'd7, 16'b0001101};
                        {2'd3, 5'd8}: entry = {5'd5, 16'b01101};
                        {2'd0, 5'd9}: entry = {5'd8, 16'b00001011};
                        {2'd1, 5'd9}: entry = {5'd8, 16'b00001110};
                        {2'd2, 5'd9}: entry = {5'd7, 16'b0001010};
                        {2'd3, 5'd9}: entry = {5'd6, 16'b001100};
                        {2'd0, 5'd10}: entry = {5'd9, 16'b000001111};
                        {2'd1, 5'd10}: entry = {5'd8, 16'b00001010};
                        {2'd2, 5'd10}: entry = {5'd8, 16'b00001101};
                        {2'd3, 5'd10}: entry = {5'd7, 16'b0001100};
                        {2'd0, 5'd11}: entry = {5'd9, 16'b000001011};
                        {2'd1, 5'd11}: entry = {5'd9, 16'b000001110};
                        {2'd2, 5'd11}: entry = {5'd8, 16'b00001001};
                        {2'd3, 5'd11}: entry = {5'd8, 16'b00001100};
                        {2'd0, 5'd12}: entry = {5'd9, 16'b000001000};
                        {2'd1, 5'd12}: entry = {5'd9, 16'b000001010};
                        {2'd2, 5'd12}: entry = {5'd9, 16'b000001101};
                        {2'd3, 5'd12}: entry = {5'd8, 16'b00001000};
                        {2'd0, 5'd13}: entry = {5'd10, 16'b0000001101};
                        {2'd1, 5'd13}: entry = {5'd9, 16'b000000111};
                        {2'd2, 5'd13}: entry = {5'd9, 16'b000001001};
                        {2'd3, 5'd13}: entry = {5'd9, 16'b000001100};
                        {2'd0, 5'd14}: entry = {5'd10, 16'b0000001001};
                        {2'd1, 5'd14}: entry = {5'd10, 16'b0000001100};
                        {2'd2, 5'd14}: entry = {5'd10, 16'b0000001011};
                        {2'd3, 5'd14}: entry = {5'd10, 16'b0000001010};
                        {2'd0, 5'd15}: entry = {5'd10, 16'b0000000101};
                        {2'd1, 5'd15}: entry = {5'd10, 16'b0000001000};
                        {2'd2, 5'd15}: entry = {5'd10, 16'b0000000111};
                        {2'd3, 5'd15}: entry = {5'd10, 16'b0000000110};
                        {2'd0, 5'd16}: entry = {5'd10, 16'b0000000001};
                        {2'd1, 5'd16}: entry = {5'd10, 16'b0000000100};
                        {2'd2, 5'd16}: entry = {5'd10, 16'b0000000011};
                        {2'd3, 5'd16}: entry = {5'd10, 16'b0000000010};
                        default: entry = '0;    // trailing ones above total, not a legal pair.
                endcase
        end

        assign {codeLen, code} = entry;

endmodule

`default_nettype wire

// ==== verilog/laneIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface laneIf;
        import cavlcPkg::*;

        // job side, driven by the dispatcher.
        logic jobValid;
        coeffCnt_t totalCoeff;
        trailOnes_t trailOnes;
        nc_t nc;

        // result side, driven by the lane one cycle after the job.
        logic resValid;
        code_t code;
        codeLen_t codeLen;
        logic resSkip;                          // nC below 4, no code produced here.

        modport dispatch (output jobValid, totalCoeff, trailOnes, nc);

        modport lane (input jobValid, totalCoeff, trailOnes, nc,
                output resValid, code, codeLen, resSkip);

        modport pack (input nc, resValid, code, codeLen, resSkip);

endinterface

`default_nettype wire
